//--- sim.f
hawk_pkg.sv
hawk_rd_arbiter.sv
hawk_pgrd_mngr.sv
hawk_decomp_mngr.sv
hawk_pgsys_top.sv
hawk_tb_mem.sv
hawk_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= hawk_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hawk_tb.sv
`timescale 1ns/1ps
// hawk page system testbench
// lookups against a preloaded image with assertions on every reply, update and write
module hawk_tb;

  localparam int                  CLK_PERIOD = 4;
  localparam int                  LKUP_MAX   = 80;  // worst case cycles for one lookup
  localparam int                  LOCK_CYC   = 20;  // cycles watched after the bus error
  localparam int                  WORST_CYC  = 7 * (LKUP_MAX + 2) + LOCK_CYC + 3;
  localparam int                  IMG_WORDS  = 1024;
  localparam hawk_pkg::mem_addr_t ERR_ADDR   = hawk_pkg::ATT_BASE + 16'd8; // table entry 8

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                lkup_valid;
  hawk_pkg::att_idx_t  lkup_idx;
  logic                ready, resp_valid, tbl_upd, wr_en, bus_err;
  hawk_pkg::resp_sts_t resp_sts;
  hawk_pkg::ppn_t      resp_ppn, upd_ppn;
  hawk_pkg::att_idx_t  upd_idx;
  hawk_pkg::mem_addr_t wr_addr, mem_addr;
  hawk_pkg::word_t     wr_data, mem_rdata;
  logic                mem_rd, mem_rvalid, mem_rerr;

  hawk_pkg::word_t     img [0:IMG_WORDS-1];               // own copy of the low image
  hawk_pkg::word_t     exp_page [0:hawk_pkg::PAGE_WORDS-1]; // expanded compressed page
  hawk_pkg::fl_idx_t   fl_head;
  hawk_pkg::resp_sts_t exp_sts;
  hawk_pkg::ppn_t      exp_ppn;
  hawk_pkg::att_idx_t  exp_idx;
  logic                exp_upd, exp_comp;
  int                  wr_cnt = 0;                         // writes seen in this lookup
  int                  errors = 0;
  int                  tests = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  hawk_pgsys_top dut0 (
    .clk_i, .rst_ni, .lkup_valid, .lkup_idx, .ready, .resp_valid, .resp_sts, .resp_ppn,
    .tbl_upd, .upd_idx, .upd_ppn, .wr_en, .wr_addr, .wr_data,
    .mem_rd, .mem_addr, .mem_rvalid, .mem_rdata, .mem_rerr, .bus_err
  );

  hawk_tb_mem mem0 (
    .clk_i, .rst_ni, .rd(mem_rd), .addr(mem_addr), .err_addr(ERR_ADDR),
    .rvalid(mem_rvalid), .rdata(mem_rdata), .rerr(mem_rerr)
  );

  always @(posedge clk_i) begin
    if (lkup_valid && ready) wr_cnt <= 0;
    else if (wr_en) wr_cnt <= wr_cnt + 1;
  end

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    errors++;
    $display("Fail %0t ns %s expected %0h got %0h", $time, sig, exp_v, got_v);
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  a_ready_lkup: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lkup_valid && !bus_err |-> ready)
    else report_mismatch("ready", 1, $sampled(ready));
  a_sts: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid |-> resp_sts == exp_sts)
    else report_mismatch("resp_sts", exp_sts, $sampled(resp_sts));
  a_ppn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid && exp_sts == hawk_pkg::RESP_OK |-> resp_ppn == exp_ppn)
    else report_mismatch("resp_ppn", exp_ppn, $sampled(resp_ppn));
  a_upd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid |-> tbl_upd == exp_upd)
    else report_mismatch("tbl_upd", exp_upd, $sampled(tbl_upd));
  a_upd_with_reply: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl_upd |-> resp_valid)
    else report_error("table update strobe without a reply");
  a_upd_idx: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl_upd |-> upd_idx == exp_idx)
    else report_mismatch("upd_idx", exp_idx, $sampled(upd_idx));
  a_upd_ppn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbl_upd |-> upd_ppn == exp_ppn)
    else report_mismatch("upd_ppn", exp_ppn, $sampled(upd_ppn));
  a_wr_allowed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en |-> exp_comp && wr_cnt < hawk_pkg::PAGE_WORDS)
    else report_error("write outside a page expansion");
  a_wr_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en |-> 32'(wr_addr) == 32'(exp_ppn) * hawk_pkg::PAGE_WORDS + wr_cnt)
    else report_mismatch("wr_addr", 32'(exp_ppn) * hawk_pkg::PAGE_WORDS + $sampled(wr_cnt),
                         $sampled(wr_addr));
  a_wr_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en && wr_cnt < hawk_pkg::PAGE_WORDS |-> wr_data == exp_page[wr_cnt])
    else report_mismatch("wr_data", exp_page[$sampled(wr_cnt)], $sampled(wr_data));
  a_wr_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid && exp_comp && exp_sts == hawk_pkg::RESP_OK |-> wr_cnt == hawk_pkg::PAGE_WORDS)
    else report_mismatch("write count", hawk_pkg::PAGE_WORDS, $sampled(wr_cnt));
  a_err_raised: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid && resp_sts == hawk_pkg::RESP_BUSERR |=> bus_err)
    else report_error("bus_err not raised after the error reply");
  a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_err |=> bus_err)
    else report_error("bus_err dropped without a reset");
  a_err_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_err |-> !ready)
    else report_mismatch("ready", 0, $sampled(ready));
  a_err_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_err |-> !resp_valid && !mem_rd)
    else report_error("reply or read issued while locked by the bus error");

  // page words expanded from consecutive compressed words by the run length rule
  task automatic expand_page(input hawk_pkg::mem_addr_t a);
    hawk_pkg::word_t w;
    int              n;
    int              k;
    n = 0;
    while (n < hawk_pkg::PAGE_WORDS) begin
      w = img[a];
      a = a + 16'd1;
      for (k = 0; k <= int'(w[31:24]) && n < hawk_pkg::PAGE_WORDS; k++) begin
        exp_page[n] = {8'h00, w[23:0]}; // zero extended value
        n++;
      end
    end
  endtask

  // works out the reply from the image, pulses the lookup, waits for resp_valid
  task automatic lookup(input hawk_pkg::att_idx_t idx);
    hawk_pkg::word_t ent;
    hawk_pkg::word_t fl_ent;
    int              n;
    ent      = img[hawk_pkg::ATT_BASE + hawk_pkg::mem_addr_t'(idx)];
    fl_ent   = img[hawk_pkg::FL_BASE + hawk_pkg::mem_addr_t'(fl_head)];
    exp_idx  = idx;
    exp_upd  = 1'b0;
    exp_comp = 1'b0;
    exp_ppn  = '0;
    if (hawk_pkg::ATT_BASE + hawk_pkg::mem_addr_t'(idx) == ERR_ADDR) begin
      exp_sts = hawk_pkg::RESP_BUSERR;
    end else if (ent[31:30] == hawk_pkg::STS_UNCOMP) begin
      exp_sts = hawk_pkg::RESP_OK;
      exp_ppn = ent[11:0];
    end else if (fl_head == hawk_pkg::FL_NULL) begin
      exp_sts = hawk_pkg::RESP_NOFREE; // head stays put
    end else begin
      exp_sts  = hawk_pkg::RESP_OK;
      exp_ppn  = fl_ent[27:16];        // frame at the head
      exp_upd  = 1'b1;
      exp_comp = (ent[31:30] == hawk_pkg::STS_COMP);
      if (exp_comp) expand_page(ent[15:0]);
    end
    lkup_valid = 1'b1;
    lkup_idx   = idx;
    @(negedge clk_i);
    lkup_valid = 1'b0;
    n = 0;
    while (!resp_valid && n < LKUP_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (!resp_valid) report_error($sformatf("no reply to the lookup of entry %0d", idx));
    else if (exp_upd) fl_head = fl_ent[7:0]; // pop
    @(negedge clk_i); // assertions sample the reply here
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %0d mismatches", tests, name, errors - err_before);
  endtask

  initial begin
    int a;
    int e;
    rst_ni     = 1'b0;
    lkup_valid = 1'b0;
    lkup_idx   = '0;
    exp_sts    = hawk_pkg::RESP_OK;
    exp_ppn    = '0;
    exp_idx    = '0;
    exp_upd    = 1'b0;
    exp_comp   = 1'b0;
    fl_head    = hawk_pkg::FL_HEAD_INIT;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    for (a = 0; a < IMG_WORDS; a++) img[a] = mem0.mem[a];

    e = errors;
    lookup(8'd2);
    end_test("uncompressed hit", e);
    e = errors;
    lookup(8'd3);
    lookup(8'd4); // next frame in the list
    end_test("deallocated pages take free frames in order", e);
    e = errors;
    lookup(8'd5);
    end_test("compressed page expanded into a free frame", e);
    e = errors;
    lookup(8'd6);
    lookup(8'd3); // list still empty and head unchanged
    end_test("empty free list", e);
    e = errors;
    lookup(8'd8);
    lkup_valid = 1'b1; // must be ignored
    lkup_idx   = 8'd2;
    @(negedge clk_i);
    lkup_valid = 1'b0;
    repeat (LOCK_CYC) @(negedge clk_i);
    end_test("bus error locks the manager", e);

    $display("tests run %0d, failed checks %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(2 * WORST_CYC * CLK_PERIOD);
    $display("watchdog expired after %0d ns, a test did not finish",
             2 * WORST_CYC * CLK_PERIOD);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- hawk_tb_mem.sv
`timescale 1ns/1ps
// hawk testbench memory
// preloaded image, random read latency of 1 to 4 cycles, error on one marked address
module hawk_tb_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rd,
  input  hawk_pkg::mem_addr_t addr,
  input  hawk_pkg::mem_addr_t err_addr,  // reads here come back with rerr
  output logic                rvalid,
  output hawk_pkg::word_t     rdata,
  output logic                rerr
);

  hawk_pkg::word_t     mem [0:65535];
  hawk_pkg::mem_addr_t addr_q;           // address of the read in flight
  logic [1:0]          left_q;           // cycles still to wait
  logic                busy_q;
  integer              seed = 49;

  initial begin
    int a;
    for (a = 0; a < 65536; a++) mem[a] = {~a[15:0], a[15:0]}; // background
    // table, 2 uncompressed, 3 4 6 deallocated, 5 compressed at 0x0200
    mem[hawk_pkg::ATT_BASE + 16'd2] = 32'h4000_00a5;
    mem[hawk_pkg::ATT_BASE + 16'd3] = 32'h0000_0000;
    mem[hawk_pkg::ATT_BASE + 16'd4] = 32'h0000_0000;
    mem[hawk_pkg::ATT_BASE + 16'd5] = 32'h8000_0200;
    mem[hawk_pkg::ATT_BASE + 16'd6] = 32'h0000_0000;
    // free list 1 -> 2 -> 3 -> null, frames 0x040 to 0x042
    mem[hawk_pkg::FL_BASE + 16'd1] = 32'h0040_0002;
    mem[hawk_pkg::FL_BASE + 16'd2] = 32'h0041_0003;
    mem[hawk_pkg::FL_BASE + 16'd3] = 32'h0042_0000;
    // runs of 4, 1, 7 and 4 words
    mem[16'h0200] = 32'h03ab_cdef;
    mem[16'h0201] = 32'h0000_0011;
    mem[16'h0202] = 32'h0612_3456;
    mem[16'h0203] = 32'h03ff_ffff;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    hawk_pkg::mem_addr_t a;
    logic [1:0]          n;
    if (!rst_ni) begin
      busy_q <= 1'b0;
      left_q <= 2'd0;
      rvalid <= 1'b0;
      rerr   <= 1'b0;
      rdata  <= '0;
    end else begin
      rvalid <= 1'b0;
      rerr   <= 1'b0;
      a = rd ? addr : addr_q;
      n = rd ? 2'($random(seed)) : left_q - 2'd1; // fresh draw per read
      if (rd || busy_q) begin
        if (n == 2'd0) begin
          busy_q <= 1'b0;
          rvalid <= 1'b1;
          rdata  <= mem[a];
          rerr   <= (a == err_addr);
        end else begin
          busy_q <= 1'b1;
          addr_q <= a;
          left_q <= n;
        end
      end
    end
  end

endmodule

//--- hawk_pgsys_top.sv
`timescale 1ns/1ps
// hawk page system top
// page read manager and decompressor sharing one memory read port
module hawk_pgsys_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                lkup_valid,
  input  hawk_pkg::att_idx_t  lkup_idx,
  output logic                ready,
  output logic                resp_valid,
  output hawk_pkg::resp_sts_t resp_sts,
  output hawk_pkg::ppn_t      resp_ppn,
  output logic                tbl_upd,
  output hawk_pkg::att_idx_t  upd_idx,
  output hawk_pkg::ppn_t      upd_ppn,
  output logic                wr_en,
  output hawk_pkg::mem_addr_t wr_addr,
  output hawk_pkg::word_t     wr_data,
  output logic                mem_rd,
  output hawk_pkg::mem_addr_t mem_addr,
  input  logic                mem_rvalid,
  input  hawk_pkg::word_t     mem_rdata,
  input  logic                mem_rerr,
  output logic                bus_err
);

  logic                pg_req;
  hawk_pkg::mem_addr_t pg_addr;
  logic                pg_rvalid;
  logic                dc_req;
  hawk_pkg::mem_addr_t dc_addr;
  logic                dc_rvalid;
  logic                decomp_start;
  logic                decomp_done;
  hawk_pkg::mem_addr_t cpage_addr; // where the compressed page sits
  hawk_pkg::ppn_t      frame_ppn;  // frame to expand into

  hawk_pgrd_mngr u_pgrd_mngr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lkup_valid   (lkup_valid),
    .lkup_idx     (lkup_idx),
    .pg_req       (pg_req),
    .pg_addr      (pg_addr),
    .pg_rvalid    (pg_rvalid),
    .rdata        (mem_rdata),
    .rerr         (mem_rerr),
    .ready        (ready),
    .resp_valid   (resp_valid),
    .resp_sts     (resp_sts),
    .resp_ppn     (resp_ppn),
    .tbl_upd      (tbl_upd),
    .upd_idx      (upd_idx),
    .upd_ppn      (upd_ppn),
    .decomp_start (decomp_start),
    .cpage_addr   (cpage_addr),
    .frame_ppn    (frame_ppn),
    .decomp_done  (decomp_done),
    .bus_err      (bus_err)
  );

  hawk_decomp_mngr u_decomp_mngr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .decomp_start (decomp_start),
    .cpage_addr   (cpage_addr),
    .frame_ppn    (frame_ppn),
    .dc_req       (dc_req),
    .dc_addr      (dc_addr),
    .dc_rvalid    (dc_rvalid),
    .rdata        (mem_rdata), // read data shared with the page read manager
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .decomp_done  (decomp_done)
  );

  hawk_rd_arbiter u_rd_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .pg_req     (pg_req),
    .pg_addr    (pg_addr),
    .pg_rvalid  (pg_rvalid),
    .dc_req     (dc_req),
    .dc_addr    (dc_addr),
    .dc_rvalid  (dc_rvalid),
    .mem_rd     (mem_rd),
    .mem_addr   (mem_addr),
    .mem_rvalid (mem_rvalid)
  );

endmodule

//--- hawk_decomp_mngr.sv
`timescale 1ns/1ps
// hawk decompression manager
// fetches run-length words and writes each run into consecutive frame words
module hawk_decomp_mngr (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                decomp_start,
  input  hawk_pkg::mem_addr_t cpage_addr,
  input  hawk_pkg::ppn_t      frame_ppn,
  output logic                dc_req,
  output hawk_pkg::mem_addr_t dc_addr,
  input  logic                dc_rvalid,
  input  hawk_pkg::word_t     rdata,
  output logic                wr_en,
  output hawk_pkg::mem_addr_t wr_addr,
  output hawk_pkg::word_t     wr_data,
  output logic                decomp_done
);

  typedef enum logic [1:0] {DC_IDLE, DC_FETCH, DC_EXPAND, DC_DONE} state_t;

  state_t                          state_q, state_d;
  hawk_pkg::mem_addr_t             rd_ptr_q; // next compressed word
  hawk_pkg::ppn_t                  frame_q;  // target frame
  logic [hawk_pkg::CW_CNT_W-1:0]   run_q;    // words left in the run, minus one
  logic [hawk_pkg::CW_VAL_W-1:0]   val_q;    // run value
  logic [hawk_pkg::PAGE_OFS_W-1:0] ofs_q;    // output word within the frame
  logic                            last_word;

  assign last_word = &ofs_q; // page size is a power of two

  always_comb begin
    state_d = state_q;
    case (state_q)
      DC_IDLE:  if (decomp_start) state_d = DC_FETCH;
      DC_FETCH: if (dc_rvalid) state_d = DC_EXPAND;
      DC_EXPAND: begin
        if (last_word) state_d = DC_DONE;       // frame full, rest of run dropped
        else if (run_q == '0) state_d = DC_FETCH;
      end
      DC_DONE:  state_d = DC_IDLE;
      default:  state_d = DC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DC_IDLE;
      ofs_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == DC_IDLE && decomp_start) ofs_q <= '0;
      else if (state_q == DC_EXPAND) ofs_q <= ofs_q + 1'b1; // one write per cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == DC_IDLE && decomp_start) begin
      rd_ptr_q <= cpage_addr;
      frame_q  <= frame_ppn;
    end else if (state_q == DC_FETCH && dc_rvalid) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
      run_q    <= rdata[hawk_pkg::CW_CNT_LSB +: hawk_pkg::CW_CNT_W];
      val_q    <= rdata[hawk_pkg::CW_VAL_LSB +: hawk_pkg::CW_VAL_W];
    end else if (state_q == DC_EXPAND) begin
      run_q <= run_q - 1'b1;
    end
  end

  assign dc_req      = (state_q == DC_FETCH); // drops the cycle after dc_rvalid
  assign dc_addr     = rd_ptr_q;
  assign wr_en       = (state_q == DC_EXPAND);
  assign wr_addr     = {frame_q, ofs_q};       // frame base plus offset
  assign wr_data     = hawk_pkg::word_t'(val_q);
  assign decomp_done = (state_q == DC_DONE);   // one cycle after the last write

  // the page read manager waits for done before it can start another page
  a_start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    decomp_start |-> (state_q == DC_IDLE));

endmodule

//--- hawk_pgrd_mngr.sv
`timescale 1ns/1ps
// hawk page read manager
// looks up a table entry, pops free frames and hands compressed pages to the decompressor
module hawk_pgrd_mngr (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                lkup_valid,
  input  hawk_pkg::att_idx_t  lkup_idx,
  output logic                pg_req,
  output hawk_pkg::mem_addr_t pg_addr,
  input  logic                pg_rvalid,
  input  hawk_pkg::word_t     rdata,
  input  logic                rerr,
  output logic                ready,
  output logic                resp_valid,
  output hawk_pkg::resp_sts_t resp_sts,
  output hawk_pkg::ppn_t      resp_ppn,
  output logic                tbl_upd,
  output hawk_pkg::att_idx_t  upd_idx,
  output hawk_pkg::ppn_t      upd_ppn,
  output logic                decomp_start,
  output hawk_pkg::mem_addr_t cpage_addr,
  output hawk_pkg::ppn_t      frame_ppn,
  input  logic                decomp_done,
  output logic                bus_err
);

  typedef enum logic [2:0] {
    IDLE,
    READ_ATT,
    CHECK_ATT,
    POP_FREE,
    WAIT_DECOMP,
    REPLY,
    BUS_ERROR
  } state_t;

  state_t              state_q, state_d;
  hawk_pkg::att_idx_t  idx_q;            // entry under lookup
  hawk_pkg::word_t     att_q;            // table entry as read
  hawk_pkg::fl_idx_t   head_q, head_d;   // free list head
  hawk_pkg::ppn_t      ppn_q, ppn_d;     // page for the reply, popped frame when allocating
  hawk_pkg::resp_sts_t sts_q, sts_d;
  logic                upd_q, upd_d;     // reply carries a table update
  logic                start_q, start_d;
  hawk_pkg::att_sts_t  att_sts;

  assign att_sts = hawk_pkg::att_sts_t'(
    att_q[hawk_pkg::ATT_STS_LSB +: $bits(hawk_pkg::att_sts_t)]);

  always_comb begin
    state_d = state_q;
    head_d  = head_q;
    ppn_d   = ppn_q;
    sts_d   = sts_q;
    upd_d   = upd_q;
    start_d = 1'b0;
    case (state_q)
      IDLE: begin
        if (lkup_valid) state_d = READ_ATT;
      end
      READ_ATT: begin
        if (pg_rvalid) begin
          if (rerr) begin
            sts_d   = hawk_pkg::RESP_BUSERR;
            upd_d   = 1'b0;
            state_d = REPLY;
          end else begin
            state_d = CHECK_ATT;
          end
        end
      end
      CHECK_ATT: begin
        if (att_sts == hawk_pkg::STS_UNCOMP) begin // hit, answer with stored ppn
          sts_d   = hawk_pkg::RESP_OK;
          ppn_d   = att_q[hawk_pkg::ATT_PTR_LSB +: $bits(hawk_pkg::ppn_t)];
          upd_d   = 1'b0;
          state_d = REPLY;
        end else if (head_q == hawk_pkg::FL_NULL) begin
          sts_d   = hawk_pkg::RESP_NOFREE; // head left as is
          upd_d   = 1'b0;
          state_d = REPLY;
        end else begin
          state_d = POP_FREE; // dealloc or compressed both need a frame
        end
      end
      POP_FREE: begin
        if (pg_rvalid) begin
          if (rerr) begin
            sts_d   = hawk_pkg::RESP_BUSERR;
            upd_d   = 1'b0;
            state_d = REPLY;
          end else begin
            head_d = rdata[hawk_pkg::FL_NEXT_LSB +: $bits(hawk_pkg::fl_idx_t)];
            ppn_d  = rdata[hawk_pkg::FL_PPN_LSB +: $bits(hawk_pkg::ppn_t)];
            sts_d  = hawk_pkg::RESP_OK;
            upd_d  = 1'b1;
            if (att_sts == hawk_pkg::STS_COMP) begin
              start_d = 1'b1; // expand into the popped frame first
              state_d = WAIT_DECOMP;
            end else begin
              state_d = REPLY;
            end
          end
        end
      end
      WAIT_DECOMP: begin
        // rerr only rises with a response, here the decompressor's fetch
        if (rerr) begin
          sts_d   = hawk_pkg::RESP_BUSERR;
          upd_d   = 1'b0;
          state_d = REPLY;
        end else if (decomp_done) begin
          state_d = REPLY;
        end
      end
      REPLY: begin
        state_d = (sts_q == hawk_pkg::RESP_BUSERR) ? BUS_ERROR : IDLE;
      end
      BUS_ERROR: state_d = BUS_ERROR; // locked until reset
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      head_q  <= hawk_pkg::FL_HEAD_INIT;
      sts_q   <= hawk_pkg::RESP_OK;
      upd_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      head_q  <= head_d;
      sts_q   <= sts_d;
      upd_q   <= upd_d;
      start_q <= start_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && lkup_valid) idx_q <= lkup_idx;
    if (state_q == READ_ATT && pg_rvalid) att_q <= rdata;
    ppn_q <= ppn_d;
  end

  assign ready   = (state_q == IDLE);
  assign bus_err = (state_q == BUS_ERROR);
  assign pg_req  = (state_q == READ_ATT) || (state_q == POP_FREE); // held until response
  assign pg_addr = (state_q == POP_FREE) ?
                   hawk_pkg::FL_BASE + hawk_pkg::mem_addr_t'(head_q) :
                   hawk_pkg::ATT_BASE + hawk_pkg::mem_addr_t'(idx_q);

  assign resp_valid   = (state_q == REPLY);
  assign resp_sts     = sts_q;
  assign resp_ppn     = ppn_q;
  assign tbl_upd      = (state_q == REPLY) && upd_q; // new status is uncompressed
  assign upd_idx      = idx_q;
  assign upd_ppn      = ppn_q;
  assign decomp_start = start_q;
  assign cpage_addr   = att_q[hawk_pkg::ATT_PTR_LSB +: $bits(hawk_pkg::mem_addr_t)];
  assign frame_ppn    = ppn_q;

  // no lookup while a request is in progress, the error lockout drops them anyway
  a_lkup_when_ready: assert property (@(posedge clk_i) disable iff (!rst_ni || bus_err)
    lkup_valid |-> ready);

  // the arbiter returns a response only for a read this FSM still waits on
  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pg_rvalid |-> pg_req);

endmodule

//--- hawk_rd_arbiter.sv
`timescale 1ns/1ps
// hawk read port arbiter
// fixed priority, page read manager first, one outstanding read at a time
module hawk_rd_arbiter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                pg_req,
  input  hawk_pkg::mem_addr_t pg_addr,
  output logic                pg_rvalid,
  input  logic                dc_req,
  input  hawk_pkg::mem_addr_t dc_addr,
  output logic                dc_rvalid,
  output logic                mem_rd,
  output hawk_pkg::mem_addr_t mem_addr,
  input  logic                mem_rvalid
);

  typedef enum logic [1:0] {OWN_NONE, OWN_PG, OWN_DC} owner_t;

  owner_t owner_q; // who the read in flight belongs to

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= OWN_NONE;
      mem_rd  <= 1'b0;
    end else begin
      mem_rd <= 1'b0; // single pulse per grant
      if (owner_q == OWN_NONE) begin
        if (pg_req) begin
          owner_q <= OWN_PG;
          mem_rd  <= 1'b1;
        end else if (dc_req) begin
          owner_q <= OWN_DC;
          mem_rd  <= 1'b1;
        end
      end else if (mem_rvalid) begin
        owner_q <= OWN_NONE; // grant released with the response
      end
    end
  end

  // address latched only when a grant can be made
  always_ff @(posedge clk_i) begin
    if (owner_q == OWN_NONE) begin
      mem_addr <= pg_req ? pg_addr : dc_addr;
    end
  end

  assign pg_rvalid = mem_rvalid && (owner_q == OWN_PG); // response to owner only
  assign dc_rvalid = mem_rvalid && (owner_q == OWN_DC);

  // memory must not answer a read that was never issued
  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid |-> (owner_q != OWN_NONE));

endmodule

//--- hawk_pkg.sv
// hawk page system package
// memory layout, entry field positions, reply codes and the shared vector types
package hawk_pkg;

  typedef logic [31:0] word_t;     // memory data word
  typedef logic [15:0] mem_addr_t; // word address
  typedef logic [11:0] ppn_t;      // physical page number
  typedef logic [7:0]  att_idx_t;  // translation table entry index
  typedef logic [7:0]  fl_idx_t;   // free list entry index

  // status field of a table entry
  typedef enum logic [1:0] {
    STS_DEALLOC = 2'd0,
    STS_UNCOMP  = 2'd1,
    STS_COMP    = 2'd2
  } att_sts_t;

  // status returned with a lookup reply
  typedef enum logic [1:0] {
    RESP_OK     = 2'd0,
    RESP_NOFREE = 2'd1,
    RESP_BUSERR = 2'd2
  } resp_sts_t;

  // memory map
  localparam mem_addr_t ATT_BASE = 16'h0000; // entry i at ATT_BASE + i
  localparam mem_addr_t FL_BASE  = 16'h0100; // entry j at FL_BASE + j

  // page geometry, frame base is ppn * PAGE_WORDS
  localparam int PAGE_WORDS = 16;
  localparam int PAGE_OFS_W = $clog2(PAGE_WORDS);

  localparam fl_idx_t FL_NULL      = 8'd0; // empty list marker
  localparam fl_idx_t FL_HEAD_INIT = 8'd1; // head after reset

  // table entry fields
  localparam int ATT_STS_LSB = 30; // status in 31:30
  localparam int ATT_PTR_LSB = 0;  // ppn or compressed page address in 15:0

  // free list entry fields
  localparam int FL_PPN_LSB  = 16; // frame ppn in 27:16
  localparam int FL_NEXT_LSB = 0;  // next index in 7:0

  // compressed word fields
  localparam int CW_CNT_LSB = 24; // run length minus one
  localparam int CW_CNT_W   = 8;
  localparam int CW_VAL_LSB = 0;  // run value, zero extended on output
  localparam int CW_VAL_W   = 24;

endpackage
